/* common/autotest_pkg.sv */
package autotest_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  sclk_speed_t;
    typedef logic [8:0]  byte_idx_t;
    typedef logic [3:0]  run_cnt_t;

    typedef enum logic [4:0]
    {
        RESET_SPI,
        WAIT_RESET,
        READ_BLOCK,
        WAIT_READ_BLOCK,
        READ_BYTE,
        WAIT_READ_BYTE,
        CHECK,
        RUN,
        WAIT_RUN,
        WRITE_BLOCK,
        WAIT_WRITE_BLOCK,
        WRITE_BYTE,
        WAIT_WRITE_BYTE,
        NEXT_RUN,
        DONE,
        HALTED
    } seq_state_t;

    localparam int    BLOCK_BYTES    = 512;
    localparam word_t CFG_BLOCK_ADDR = 32'h0010_0000;
    localparam word_t CFG_SIGNATURE  = 32'hAABB_CCDD;
    localparam int    MAX_RUNS       = 8;

    // sized for simulation
    localparam word_t TIMEOUT_CYCLES = 32'd2000;

    // block layout
    localparam byte_idx_t OFS_SIGNATURE  = 9'd0;
    localparam byte_idx_t OFS_RUNS       = 9'd4;
    localparam byte_idx_t OFS_N_BLOCKS   = 9'd5;
    localparam byte_idx_t OFS_SCLK_SPEED = 9'd9;
    localparam byte_idx_t OFS_CMD18      = 9'd10;
    // four bytes per run, lsb first
    localparam byte_idx_t OFS_TIMERS     = 9'd12;

endpackage

/* hw/block_sequencer.sv */
`timescale 1ns/1ps

module block_sequencer
    import autotest_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      spi_busy_i,
    output logic      spi_rst_o,
    output logic      spi_r_block_o,
    output logic      spi_r_byte_o,
    output logic      spi_w_block_o,
    output logic      spi_w_byte_o,
    output logic      uut_rst_o,
    output logic      uut_sel_o,
    output logic      done_o,
    output logic      error_o,
    output logic      cap_o,
    output byte_idx_t idx_o,
    input  logic      cfg_valid_i,
    input  run_cnt_t  runs_i,
    output logic      start_o,
    input  logic      run_done_i,
    output logic      log_o,
    output run_cnt_t  run_idx_o
);

    seq_state_t state;
    seq_state_t state_next;
    byte_idx_t  idx;
    run_cnt_t   run_cnt;
    run_cnt_t   run_next;
    logic       last_byte;

    assign last_byte = (idx == byte_idx_t'(BLOCK_BYTES - 1));
    assign run_next  = run_cnt + 4'd1;

    always_comb
    begin
        state_next = state;
        case (state)
            RESET_SPI:        if (spi_busy_i) state_next = WAIT_RESET;
            WAIT_RESET:       if (!spi_busy_i) state_next = READ_BLOCK;
            READ_BLOCK:       if (spi_busy_i) state_next = WAIT_READ_BLOCK;
            WAIT_READ_BLOCK:  if (!spi_busy_i) state_next = READ_BYTE;
            READ_BYTE:        if (spi_busy_i) state_next = WAIT_READ_BYTE;
            WAIT_READ_BYTE:
            begin
                if (!spi_busy_i)
                    state_next = last_byte ? CHECK : READ_BYTE;
            end
            CHECK:            state_next = cfg_valid_i ? RUN : HALTED;
            RUN:              state_next = WAIT_RUN;
            WAIT_RUN:         if (run_done_i) state_next = WRITE_BLOCK;
            WRITE_BLOCK:      if (spi_busy_i) state_next = WAIT_WRITE_BLOCK;
            WAIT_WRITE_BLOCK: if (!spi_busy_i) state_next = WRITE_BYTE;
            WRITE_BYTE:       if (spi_busy_i) state_next = WAIT_WRITE_BYTE;
            WAIT_WRITE_BYTE:
            begin
                if (!spi_busy_i)
                    state_next = last_byte ? NEXT_RUN : WRITE_BYTE;
            end
            NEXT_RUN:         state_next = (run_next == runs_i) ? DONE : RESET_SPI;
            default:          state_next = state;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= RESET_SPI;
        else
            state <= state_next;
    end

    // requests are decoded from the next state so they line up with the state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            spi_rst_o     <= 1'b0;
            spi_r_block_o <= 1'b0;
            spi_r_byte_o  <= 1'b0;
            spi_w_block_o <= 1'b0;
            spi_w_byte_o  <= 1'b0;
            uut_rst_o     <= 1'b0;
            uut_sel_o     <= 1'b0;
            done_o        <= 1'b0;
            error_o       <= 1'b0;
        end
        else
        begin
            spi_rst_o     <= (state_next == RESET_SPI);
            spi_r_block_o <= state_next inside {READ_BLOCK, WAIT_READ_BLOCK,
                                                READ_BYTE, WAIT_READ_BYTE};
            spi_r_byte_o  <= (state_next == READ_BYTE);
            spi_w_block_o <= state_next inside {WRITE_BLOCK, WAIT_WRITE_BLOCK,
                                                WRITE_BYTE, WAIT_WRITE_BYTE};
            spi_w_byte_o  <= (state_next == WRITE_BYTE);
            uut_rst_o     <= state_next inside {RESET_SPI, WAIT_RESET, READ_BLOCK,
                                                WAIT_READ_BLOCK, READ_BYTE,
                                                WAIT_READ_BYTE};
            uut_sel_o     <= state_next inside {CHECK, RUN, WAIT_RUN};
            done_o        <= (state_next == DONE);
            error_o       <= (state_next == HALTED);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idx     <= '0;
            run_cnt <= '0;
        end
        else
        begin
            if (state == WAIT_READ_BLOCK || state == WAIT_WRITE_BLOCK)
                idx <= '0;
            else if ((state == WAIT_READ_BYTE || state == WAIT_WRITE_BYTE) && !spi_busy_i)
                idx <= idx + 9'd1;
            if (state == NEXT_RUN)
                run_cnt <= run_next;
        end
    end

    // byte is valid once busy drops after a read
    assign cap_o     = (state == WAIT_READ_BYTE) && !spi_busy_i;
    assign idx_o     = idx;
    assign start_o   = (state == RUN);
    assign log_o     = (state == WAIT_RUN) && run_done_i;
    assign run_idx_o = run_cnt;

endmodule

/* hw/config_decoder.sv */
`timescale 1ns/1ps

module config_decoder
    import autotest_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cap_i,
    input  byte_idx_t   idx_i,
    input  byte_t       data_i,
    output word_t       signature_o,
    output run_cnt_t    runs_o,
    output word_t       n_blocks_o,
    output sclk_speed_t sclk_speed_o,
    output logic        cmd18_o,
    output logic        cfg_valid_o
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            signature_o  <= '0;
            runs_o       <= '0;
            n_blocks_o   <= '0;
            sclk_speed_o <= '0;
            cmd18_o      <= 1'b0;
        end
        else if (cap_i)
        begin
            case (idx_i)
                // signature arrives msb first
                OFS_SIGNATURE:          signature_o[31:24] <= data_i;
                OFS_SIGNATURE + 9'd1:   signature_o[23:16] <= data_i;
                OFS_SIGNATURE + 9'd2:   signature_o[15:8]  <= data_i;
                OFS_SIGNATURE + 9'd3:   signature_o[7:0]   <= data_i;
                OFS_RUNS:
                begin
                    if (data_i > 8'd15)
                        runs_o <= 4'd15;
                    else
                        runs_o <= data_i[3:0];
                end
                OFS_N_BLOCKS:           n_blocks_o[7:0]    <= data_i;
                OFS_N_BLOCKS + 9'd1:    n_blocks_o[15:8]   <= data_i;
                OFS_N_BLOCKS + 9'd2:    n_blocks_o[23:16]  <= data_i;
                OFS_N_BLOCKS + 9'd3:    n_blocks_o[31:24]  <= data_i;
                OFS_SCLK_SPEED:         sclk_speed_o       <= data_i[4:0];
                OFS_CMD18:              cmd18_o            <= data_i[0];
                default:
                begin
                end
            endcase
        end
    end

    assign cfg_valid_o = (signature_o == CFG_SIGNATURE) &&
                         (runs_o != 4'd0) &&
                         (runs_o <= run_cnt_t'(MAX_RUNS));

endmodule

/* hw/test_executor.sv */
`timescale 1ns/1ps

module test_executor
    import autotest_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start_i,
    input  logic  uut_finish_i,
    output logic  uut_start_o,
    output logic  done_o,
    output word_t elapsed_o
);

    logic running;
    logic stop;

    // finish wins over a count that is about to hit the limit
    assign stop = running && (uut_finish_i || elapsed_o >= TIMEOUT_CYCLES);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running   <= 1'b0;
            done_o    <= 1'b0;
            elapsed_o <= '0;
        end
        else
        begin
            done_o <= stop;
            if (start_i && !running)
            begin
                running   <= 1'b1;
                elapsed_o <= '0;
            end
            else if (stop)
                running <= 1'b0;
            else if (running)
                elapsed_o <= elapsed_o + 32'd1;
        end
    end

    assign uut_start_o = running;

endmodule

/* hw/result_formatter.sv */
`timescale 1ns/1ps

module result_formatter
    import autotest_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        log_i,
    input  run_cnt_t    run_idx_i,
    input  word_t       elapsed_i,
    input  word_t       signature_i,
    input  run_cnt_t    runs_i,
    input  word_t       n_blocks_i,
    input  sclk_speed_t sclk_speed_i,
    input  logic        cmd18_i,
    input  byte_idx_t   idx_i,
    output byte_t       byte_o
);

    word_t     timer_log [MAX_RUNS];
    byte_idx_t timer_ofs;
    logic      in_timers;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < MAX_RUNS; i++)
                timer_log[i] <= '0;
        end
        else if (log_i && run_idx_i < run_cnt_t'(MAX_RUNS))
            timer_log[run_idx_i[2:0]] <= elapsed_i;
    end

    assign timer_ofs = idx_i - OFS_TIMERS;
    assign in_timers = (idx_i >= OFS_TIMERS) &&
                       (timer_ofs < byte_idx_t'(4 * MAX_RUNS));

    always_comb
    begin
        byte_o = '0;
        case (idx_i)
            OFS_SIGNATURE:        byte_o = signature_i[31:24];
            OFS_SIGNATURE + 9'd1: byte_o = signature_i[23:16];
            OFS_SIGNATURE + 9'd2: byte_o = signature_i[15:8];
            OFS_SIGNATURE + 9'd3: byte_o = signature_i[7:0];
            OFS_RUNS:             byte_o = {4'd0, runs_i};
            OFS_N_BLOCKS:         byte_o = n_blocks_i[7:0];
            OFS_N_BLOCKS + 9'd1:  byte_o = n_blocks_i[15:8];
            OFS_N_BLOCKS + 9'd2:  byte_o = n_blocks_i[23:16];
            OFS_N_BLOCKS + 9'd3:  byte_o = n_blocks_i[31:24];
            OFS_SCLK_SPEED:       byte_o = {3'd0, sclk_speed_i};
            OFS_CMD18:            byte_o = {7'd0, cmd18_i};
            default:
            begin
                // slot in bits 4:2, byte lane in bits 1:0
                if (in_timers)
                    byte_o = timer_log[timer_ofs[4:2]][timer_ofs[1:0] * 8 +: 8];
            end
        endcase
    end

endmodule

/* hw/autotest_top.sv */
`timescale 1ns/1ps

module autotest_top
    import autotest_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        spi_busy_i,
    input  byte_t       spi_data_i,
    output logic        spi_rst_o,
    output logic        spi_r_block_o,
    output logic        spi_r_byte_o,
    output logic        spi_w_block_o,
    output logic        spi_w_byte_o,
    output byte_t       spi_data_o,
    output word_t       spi_block_addr_o,
    output logic        uut_rst_o,
    output logic        uut_sel_o,
    output logic        uut_start_o,
    input  logic        uut_finish_i,
    output word_t       uut_n_blocks_o,
    output sclk_speed_t uut_sclk_speed_o,
    output logic        uut_cmd18_o,
    output logic        done_o,
    output logic        error_o
);

    logic      cap;
    byte_idx_t idx;
    logic      cfg_valid;
    run_cnt_t  runs;
    word_t     signature;
    logic      start;
    logic      run_done;
    word_t     elapsed;
    logic      log_run;
    run_cnt_t  run_idx;

    // single config / result block
    assign spi_block_addr_o = CFG_BLOCK_ADDR;

    block_sequencer block_sequencer_inst
    (
        .clk           (clk),
        .rst           (rst),
        .spi_busy_i    (spi_busy_i),
        .spi_rst_o     (spi_rst_o),
        .spi_r_block_o (spi_r_block_o),
        .spi_r_byte_o  (spi_r_byte_o),
        .spi_w_block_o (spi_w_block_o),
        .spi_w_byte_o  (spi_w_byte_o),
        .uut_rst_o     (uut_rst_o),
        .uut_sel_o     (uut_sel_o),
        .done_o        (done_o),
        .error_o       (error_o),
        .cap_o         (cap),
        .idx_o         (idx),
        .cfg_valid_i   (cfg_valid),
        .runs_i        (runs),
        .start_o       (start),
        .run_done_i    (run_done),
        .log_o         (log_run),
        .run_idx_o     (run_idx)
    );

    config_decoder config_decoder_inst
    (
        .clk          (clk),
        .rst          (rst),
        .cap_i        (cap),
        .idx_i        (idx),
        .data_i       (spi_data_i),
        .signature_o  (signature),
        .runs_o       (runs),
        .n_blocks_o   (uut_n_blocks_o),
        .sclk_speed_o (uut_sclk_speed_o),
        .cmd18_o      (uut_cmd18_o),
        .cfg_valid_o  (cfg_valid)
    );

    test_executor test_executor_inst
    (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start),
        .uut_finish_i (uut_finish_i),
        .uut_start_o  (uut_start_o),
        .done_o       (run_done),
        .elapsed_o    (elapsed)
    );

    result_formatter result_formatter_inst
    (
        .clk          (clk),
        .rst          (rst),
        .log_i        (log_run),
        .run_idx_i    (run_idx),
        .elapsed_i    (elapsed),
        .signature_i  (signature),
        .runs_i       (runs),
        .n_blocks_i   (uut_n_blocks_o),
        .sclk_speed_i (uut_sclk_speed_o),
        .cmd18_i      (uut_cmd18_o),
        .idx_i        (idx),
        .byte_o       (spi_data_o)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
    output logic clk_o
);

    // 10 ns period
    initial
    begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

endmodule

/* testbench/sd_card_model.sv */
`timescale 1ns/1ps

module sd_card_model
    import autotest_pkg::*;
(
    input  logic  clk,
    input  logic  rst_i,
    input  byte_t image_i [BLOCK_BYTES],
    input  logic  spi_rst_i,
    input  logic  spi_r_block_i,
    input  logic  spi_r_byte_i,
    input  logic  spi_w_block_i,
    input  logic  spi_w_byte_i,
    input  byte_t spi_data_i,
    output logic  spi_busy_o,
    output byte_t spi_data_o,
    output byte_t block_o [BLOCK_BYTES],
    output int    rd_blocks_o,
    output int    wr_blocks_o
);

    logic      busy_q = 1'b0;
    byte_t     data_q = 8'h00;
    int        busy_left;
    byte_idx_t ptr;
    logic      r_block_q;
    logic      w_block_q;

    assign spi_busy_o = busy_q;
    assign spi_data_o = data_q;

    always @(posedge clk)
    begin
        if (rst_i)
        begin
            busy_q      <= 1'b0;
            data_q      <= 8'h00;
            busy_left   <= 0;
            ptr         <= '0;
            r_block_q   <= 1'b0;
            w_block_q   <= 1'b0;
            rd_blocks_o <= 0;
            wr_blocks_o <= 0;
            block_o     <= image_i;
        end
        else
        begin
            // block requests stay high over the byte loop, so act on the rising edge
            r_block_q <= spi_r_block_i;
            w_block_q <= spi_w_block_i;
            if (busy_left > 1)
                busy_left <= busy_left - 1;
            else if (busy_left == 1)
            begin
                busy_left <= 0;
                busy_q    <= 1'b0;
            end
            else if (spi_rst_i || spi_r_byte_i || spi_w_byte_i ||
                     (spi_r_block_i && !r_block_q) || (spi_w_block_i && !w_block_q))
            begin
                busy_left <= 1 + int'($urandom_range(7));
                busy_q    <= 1'b1;
                if (spi_r_byte_i)
                begin
                    data_q <= block_o[ptr];
                    ptr    <= ptr + 9'd1;
                end
                else if (spi_w_byte_i)
                begin
                    block_o[ptr] <= spi_data_i;
                    ptr          <= ptr + 9'd1;
                end
                else if (spi_r_block_i && !r_block_q)
                begin
                    rd_blocks_o <= rd_blocks_o + 1;
                    ptr         <= '0;
                end
                else if (spi_w_block_i && !w_block_q)
                begin
                    wr_blocks_o <= wr_blocks_o + 1;
                    ptr         <= '0;
                end
            end
        end
    end

endmodule

/* testbench/autotest_asserts.sv */
`timescale 1ns/1ps

module autotest_asserts
(
    input logic clk,
    input logic rst,
    input logic r_byte_i,
    input logic w_byte_i,
    input logic w_block_i,
    input logic uut_rst_i,
    input logic uut_start_i,
    input logic uut_sel_i,
    input logic done_i,
    input logic error_i
);

    int excl_fails = 0;
    int sel_fails = 0;
    int end_fails = 0;
    int wr_fails = 0;

    byte_req_excl: assert property (@(posedge clk) disable iff (rst) !(r_byte_i && w_byte_i))
    else
    begin
        excl_fails++;
        $error("byte read and byte write requested together");
    end

    start_needs_sel: assert property (@(posedge clk) disable iff (rst) uut_start_i |-> uut_sel_i)
    else
    begin
        sel_fails++;
        $error("unit started without select");
    end

    done_error_excl: assert property (@(posedge clk) disable iff (rst) !(done_i && error_i))
    else
    begin
        end_fails++;
        $error("done and error high together");
    end

    // no writes while the card config is being read
    no_write_in_rst: assert property (@(posedge clk) disable iff (rst)
                                      uut_rst_i |-> !(w_block_i || w_byte_i))
    else
    begin
        wr_fails++;
        $error("write request while unit held in reset");
    end

endmodule

bind autotest_top autotest_asserts autotest_asserts_inst
(
    .clk         (clk),
    .rst         (rst),
    .r_byte_i    (spi_r_byte_o),
    .w_byte_i    (spi_w_byte_o),
    .w_block_i   (spi_w_block_o),
    .uut_rst_i   (uut_rst_o),
    .uut_start_i (uut_start_o),
    .uut_sel_i   (uut_sel_o),
    .done_i      (done_o),
    .error_i     (error_o)
);

/* testbench/autotest_tb.sv */
`timescale 1ns/1ps

module autotest_tb
    import autotest_pkg::*;
;

    // invalid configs stop after one read and count as one run
    localparam int TOTAL_RUNS      = 3 + 2 + 1 + 1;
    localparam int RUN_CYCLES      = 12 * 1024 + int'(TIMEOUT_CYCLES);
    localparam int WATCHDOG_CYCLES = TOTAL_RUNS * RUN_CYCLES + 4 * 32;

    logic        clk;
    logic        rst = 1'b1;
    logic        spi_busy;
    byte_t       spi_rd_data;
    logic        spi_rst_req;
    logic        spi_r_block;
    logic        spi_r_byte;
    logic        spi_w_block;
    logic        spi_w_byte;
    byte_t       spi_wr_data;
    word_t       spi_block_addr;
    logic        uut_rst;
    logic        uut_sel;
    logic        uut_start;
    logic        uut_finish = 1'b0;
    word_t       uut_n_blocks;
    sclk_speed_t uut_sclk_speed;
    logic        uut_cmd18;
    logic        done;
    logic        error;

    byte_t cfg_image [BLOCK_BYTES];
    byte_t card_block [BLOCK_BYTES];
    int    rd_blocks;
    int    wr_blocks;

    word_t cfg_sig;
    byte_t cfg_runs;
    word_t cfg_n_blocks;
    byte_t cfg_sclk;
    byte_t cfg_cmd18;
    int    run_delay [MAX_RUNS];

    int    uut_cycles;
    int    uut_run;
    int    errors = 0;
    int    starts;
    logic  start_q;
    logic  end_seen = 1'b0;

    tb_clock tb_clock_inst
    (
        .clk_o (clk)
    );

    sd_card_model card_model_inst
    (
        .clk           (clk),
        .rst_i         (rst),
        .image_i       (cfg_image),
        .spi_rst_i     (spi_rst_req),
        .spi_r_block_i (spi_r_block),
        .spi_r_byte_i  (spi_r_byte),
        .spi_w_block_i (spi_w_block),
        .spi_w_byte_i  (spi_w_byte),
        .spi_data_i    (spi_wr_data),
        .spi_busy_o    (spi_busy),
        .spi_data_o    (spi_rd_data),
        .block_o       (card_block),
        .rd_blocks_o   (rd_blocks),
        .wr_blocks_o   (wr_blocks)
    );

    autotest_top autotest_top_inst
    (
        .clk              (clk),
        .rst              (rst),
        .spi_busy_i       (spi_busy),
        .spi_data_i       (spi_rd_data),
        .spi_rst_o        (spi_rst_req),
        .spi_r_block_o    (spi_r_block),
        .spi_r_byte_o     (spi_r_byte),
        .spi_w_block_o    (spi_w_block),
        .spi_w_byte_o     (spi_w_byte),
        .spi_data_o       (spi_wr_data),
        .spi_block_addr_o (spi_block_addr),
        .uut_rst_o        (uut_rst),
        .uut_sel_o        (uut_sel),
        .uut_start_o      (uut_start),
        .uut_finish_i     (uut_finish),
        .uut_n_blocks_o   (uut_n_blocks),
        .uut_sclk_speed_o (uut_sclk_speed),
        .uut_cmd18_o      (uut_cmd18),
        .done_o           (done),
        .error_o          (error)
    );

    // fake unit finishes after run_delay cycles of start
    always @(posedge clk)
    begin
        if (rst)
        begin
            uut_cycles <= 0;
            uut_run    <= 0;
            uut_finish <= 1'b0;
        end
        else if (uut_start)
        begin
            uut_cycles <= uut_cycles + 1;
            if (uut_cycles + 1 == run_delay[uut_run])
                uut_finish <= 1'b1;
        end
        else
        begin
            if (uut_cycles != 0)
                uut_run <= uut_run + 1;
            uut_cycles <= 0;
            uut_finish <= 1'b0;
        end
    end

    task automatic check_byte(input string name, input int idx, input byte_t got,
                              input byte_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s[%0d] got 0x%02h expected 0x%02h", name, idx, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_sclk(input string name, input sclk_speed_t got,
                              input sclk_speed_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH %s got 0x%01h expected 0x%01h", name, got, exp);
        end
    endtask

    // expected result block byte from the block layout
    function automatic byte_t expected_byte(int idx);
        int    slot;
        word_t timer;
        slot = (idx - int'(OFS_TIMERS)) / 4;
        if (idx < int'(OFS_RUNS))
            return byte_t'(cfg_sig >> (8 * (3 - idx)));
        if (idx == int'(OFS_RUNS))
            return (cfg_runs > 8'd15) ? 8'd15 : cfg_runs;
        if (idx >= int'(OFS_N_BLOCKS) && idx < int'(OFS_SCLK_SPEED))
            return byte_t'(cfg_n_blocks >> (8 * (idx - int'(OFS_N_BLOCKS))));
        if (idx == int'(OFS_SCLK_SPEED))
            return {3'd0, cfg_sclk[4:0]};
        if (idx == int'(OFS_CMD18))
            return {7'd0, cfg_cmd18[0]};
        if (idx >= int'(OFS_TIMERS) && slot < int'(cfg_runs))
        begin
            timer = (run_delay[slot] > int'(TIMEOUT_CYCLES)) ? TIMEOUT_CYCLES
                                                             : word_t'(run_delay[slot]);
            return byte_t'(timer >> (8 * ((idx - int'(OFS_TIMERS)) % 4)));
        end
        return 8'h00;
    endfunction

    function automatic int assertion_failures();
        return autotest_top_inst.autotest_asserts_inst.excl_fails +
               autotest_top_inst.autotest_asserts_inst.sel_fails +
               autotest_top_inst.autotest_asserts_inst.end_fails +
               autotest_top_inst.autotest_asserts_inst.wr_fails;
    endfunction

    task automatic compare_result();
        logic valid;
        valid = (cfg_sig == CFG_SIGNATURE) && (cfg_runs >= 8'd1) &&
                (cfg_runs <= byte_t'(MAX_RUNS));
        check_bit("done_o", done, valid);
        check_bit("error_o", error, !valid);
        check_word("spi_block_addr_o", spi_block_addr, CFG_BLOCK_ADDR);
        if (valid)
        begin
            check_word("read_blocks", word_t'(rd_blocks), word_t'(cfg_runs));
            check_word("write_blocks", word_t'(wr_blocks), word_t'(cfg_runs));
            check_word("uut_starts", word_t'(starts), word_t'(cfg_runs));
            for (int i = 0; i < BLOCK_BYTES; i++)
                check_byte("card_block", i, card_block[i], expected_byte(i));
        end
        else
        begin
            check_word("read_blocks", word_t'(rd_blocks), 32'd1);
            check_word("write_blocks", word_t'(wr_blocks), 32'd0);
            check_word("uut_starts", word_t'(starts), 32'd0);
        end
    endtask

    always @(posedge clk)
    begin
        start_q <= uut_start;
        if (rst)
        begin
            starts   <= 0;
            end_seen <= 1'b0;
        end
        else
        begin
            // parameters seen by the unit when it starts
            if (uut_start && !start_q)
            begin
                starts <= starts + 1;
                check_word("uut_n_blocks_o", uut_n_blocks, cfg_n_blocks);
                check_sclk("uut_sclk_speed_o", uut_sclk_speed, sclk_speed_t'(cfg_sclk));
                check_bit("uut_cmd18_o", uut_cmd18, cfg_cmd18[0]);
                check_bit("uut_rst_o", uut_rst, 1'b0);
            end
            // unit held in reset while reading, deselected during transfers
            if (spi_r_byte)
            begin
                check_bit("uut_rst_o", uut_rst, 1'b1);
                check_bit("uut_sel_o", uut_sel, 1'b0);
            end
            if (spi_w_byte)
            begin
                check_bit("uut_rst_o", uut_rst, 1'b0);
                check_bit("uut_sel_o", uut_sel, 1'b0);
            end
            if ((done || error) && !end_seen)
            begin
                end_seen <= 1'b1;
                compare_result();
            end
        end
    end

    task automatic build_config_image();
        for (int i = 0; i < BLOCK_BYTES; i++)
            cfg_image[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'hA5;
        for (int i = 0; i < 4; i++)
        begin
            cfg_image[int'(OFS_SIGNATURE) + i] = byte_t'(cfg_sig >> (8 * (3 - i)));
            cfg_image[int'(OFS_N_BLOCKS) + i]  = byte_t'(cfg_n_blocks >> (8 * i));
        end
        cfg_image[int'(OFS_RUNS)]       = cfg_runs;
        cfg_image[int'(OFS_SCLK_SPEED)] = cfg_sclk;
        cfg_image[int'(OFS_CMD18)]      = cfg_cmd18;
    endtask

    task automatic run_scenario(input word_t sig, input byte_t runs, input int long_slot);
        cfg_sig      = sig;
        cfg_runs     = runs;
        cfg_n_blocks = $urandom;
        cfg_sclk     = byte_t'($urandom);
        cfg_cmd18    = byte_t'($urandom);
        for (int k = 0; k < MAX_RUNS; k++)
        begin
            if (k == long_slot)
                run_delay[k] = int'(TIMEOUT_CYCLES) + 500;
            else
                run_delay[k] = 5 + int'($urandom_range(55));
        end
        build_config_image();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (!end_seen)
            @(posedge clk);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("timeout: no done or error within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(71));
        run_scenario(CFG_SIGNATURE, 8'd3, -1);
        // second run times out
        run_scenario(CFG_SIGNATURE, 8'd2, 1);
        run_scenario(32'hAABB_CCDC, 8'd2, -1);
        run_scenario(CFG_SIGNATURE, 8'd0, -1);
        $display("check errors: %0d, assertion failures: %0d", errors, assertion_failures());
        if (errors == 0 && assertion_failures() == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* vlog.f */
common/autotest_pkg.sv
hw/block_sequencer.sv
hw/config_decoder.sv
hw/test_executor.sv
hw/result_formatter.sv
hw/autotest_top.sv
testbench/tb_clock.sv
testbench/sd_card_model.sv
testbench/autotest_asserts.sv
testbench/autotest_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= autotest_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) | tee /dev/stderr | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
